//--- src.f
+incdir+.
memCheckPkg.sv
adrDec.sv
adrDecs.sv
pmaChecker.sv
pmpChecker.sv
memCheckTop.sv
memCheckTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= memCheckTb
FILELIST  ?= src.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJDIR)

//--- memCheckTb.sv
// Memory check unit testbench
// Directed tests of region attributes and region legality, followed by
// the PMP privilege default, NAPOT, NA4, TOR priority and lock rules.

`default_nettype none

module memCheckTb import memCheckPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // Size and privilege codes
  localparam sizeT szByte = 2'd0;
  localparam sizeT szWord = 2'd2;
  localparam privT privUser  = 2'd0;
  localparam privT privSuper = 2'd1;

  logic        clk;
  logic        arstN;
  paddrT       physAdr;
  sizeT        size;
  logic        execAccess;
  logic        readAccess;
  logic        writeAccess;
  privT        privMode;
  logic        pmpWrEn;
  logic        pmpWrCfg;
  logic [1:0]  pmpWrIdx;
  logic [31:0] pmpWrData;
  logic        cacheable;
  logic        idempotent;
  logic        atomicAllowed;
  logic        instrAccessFault;
  logic        loadAccessFault;
  logic        storeAccessFault;

  int     errors;
  int     checks;
  int     testsRun;
  integer seed;

  memCheckTop u_memCheckTop (
    .clk, .arstN, .physAdr, .size, .execAccess, .readAccess, .writeAccess,
    .privMode, .pmpWrEn, .pmpWrCfg, .pmpWrIdx, .pmpWrData, .cacheable,
    .idempotent, .atomicAllowed, .instrAccessFault, .loadAccessFault,
    .storeAccessFault
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Reset is held over the first 8 rising edges
  initial begin
    arstN = 1'b0;
    repeat (8) @(posedge clk);
    #10;
    arstN = 1'b1;
  end

  // Hard limit on the whole run
  initial begin
    #200_000;
    $display("Timeout: the run did not complete in time");
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkFaults(input logic expI, input logic expL, input logic expS);
    compare("instrAccessFault", 32'(instrAccessFault), 32'(expI));
    compare("loadAccessFault", 32'(loadAccessFault), 32'(expL));
    compare("storeAccessFault", 32'(storeAccessFault), 32'(expS));
  endtask

  task automatic checkAttrs(input logic expC, input logic expI, input logic expA);
    compare("cacheable", 32'(cacheable), 32'(expC));
    compare("idempotent", 32'(idempotent), 32'(expI));
    compare("atomicAllowed", 32'(atomicAllowed), 32'(expA));
  endtask

  // Configuration byte: lock in bit 7, mode in bits 4:3, then X, W, R
  function automatic logic [31:0] makeCfg(input logic lock, input logic [1:0] mode,
                                          input logic x, input logic w, input logic r);
    return {24'd0, lock, 2'b00, mode, x, w, r};
  endfunction

  // NAPOT encoding of a naturally aligned block of at least 8 bytes
  function automatic logic [31:0] napotAdr(input logic [31:0] base, input logic [31:0] bytes);
    return (base >> 2) | ((bytes >> 3) - 32'd1);
  endfunction

  task automatic initInputs();
    physAdr     = '0;
    size        = szWord;
    execAccess  = 1'b0;
    readAccess  = 1'b0;
    writeAccess = 1'b0;
    privMode    = privMachine;
    pmpWrEn     = 1'b0;
    pmpWrCfg    = 1'b0;
    pmpWrIdx    = 2'd0;
    pmpWrData   = '0;
  endtask

  // Present one access; outputs are combinational and settle well before
  // the sample point 30 ns after the edge
  task automatic access(input paddrT adr, input sizeT sz, input logic x, input logic r,
                        input logic w, input privT priv);
    @(posedge clk);
    #10;
    physAdr     = adr;
    size        = sz;
    execAccess  = x;
    readAccess  = r;
    writeAccess = w;
    privMode    = priv;
    #20;
  endtask

  // One write through the PMP port, taken on the following rising edge
  task automatic pmpWrite(input logic isCfg, input logic [1:0] idx, input logic [31:0] data);
    @(posedge clk);
    #10;
    pmpWrEn   = 1'b1;
    pmpWrCfg  = isCfg;
    pmpWrIdx  = idx;
    pmpWrData = data;
    @(posedge clk);
    #10;
    pmpWrEn   = 1'b0;
  endtask

  task automatic waitForReset(output logic released);
    int cycles;
    cycles = 0;
    while (arstN !== 1'b1 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    released = (arstN === 1'b1);
  endtask

  task automatic finishTest(input string name, input int errBefore);
    testsRun++;
    if (errors == errBefore) begin
      $display("test %0d %s: ok", testsRun, name);
    end else begin
      $display("test %0d %s: %0d errors", testsRun, name, errors - errBefore);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  // Machine mode with every entry off, so only the region rules apply
  task automatic testAttributes();
    int errBefore;
    errBefore = errors;
    access(32'h8000_0100, szWord, 1'b0, 1'b1, 1'b0, privMachine);
    checkAttrs(1'b1, 1'b1, 1'b1);
    checkFaults(1'b0, 1'b0, 1'b0);
    access(32'h7000_0010, szWord, 1'b0, 1'b1, 1'b0, privMachine);
    checkAttrs(1'b1, 1'b1, 1'b1);
    checkFaults(1'b0, 1'b0, 1'b0);
    access(32'h2000_0040, szWord, 1'b0, 1'b1, 1'b0, privMachine);
    checkAttrs(1'b1, 1'b0, 1'b0);
    checkFaults(1'b0, 1'b0, 1'b0);
    access(32'h1000_0004, szByte, 1'b0, 1'b1, 1'b0, privMachine);
    checkAttrs(1'b0, 1'b0, 1'b0);
    checkFaults(1'b0, 1'b0, 1'b0);
    // Unmapped but idle, no access level high
    access(32'h4000_0000, szWord, 1'b0, 1'b0, 1'b0, privMachine);
    checkFaults(1'b0, 1'b0, 1'b0);
    finishTest("attributes", errBefore);
  endtask

  task automatic testRegionLegality();
    int errBefore;
    errBefore = errors;
    // UART takes bytes only
    access(32'h1000_0004, szWord, 1'b0, 1'b1, 1'b0, privMachine);
    checkFaults(1'b0, 1'b1, 1'b0);
    // CLINT takes words only
    access(32'h0200_4000, szByte, 1'b0, 1'b1, 1'b0, privMachine);
    checkFaults(1'b0, 1'b1, 1'b0);
    access(32'h0200_4000, szWord, 1'b0, 1'b0, 1'b1, privMachine);
    checkFaults(1'b0, 1'b0, 1'b0);
    // Boot ROM is read and execute only
    access(32'h0000_1010, szWord, 1'b0, 1'b0, 1'b1, privMachine);
    checkFaults(1'b0, 1'b0, 1'b1);
    // GPIO cannot be executed from
    access(32'h1006_0010, szWord, 1'b1, 1'b0, 1'b0, privMachine);
    checkFaults(1'b1, 1'b0, 1'b0);
    // No region at all, each kind faults on its own
    access(32'h4000_0000, szWord, 1'b1, 1'b0, 1'b0, privMachine);
    checkFaults(1'b1, 1'b0, 1'b0);
    access(32'h4000_0000, szWord, 1'b0, 1'b1, 1'b0, privMachine);
    checkFaults(1'b0, 1'b1, 1'b0);
    access(32'h4000_0000, szWord, 1'b0, 1'b0, 1'b1, privMachine);
    checkFaults(1'b0, 1'b0, 1'b1);
    finishTest("region legality", errBefore);
  endtask

  // No entry matches after reset, so only machine mode gets through
  task automatic testPrivDefault();
    int errBefore;
    errBefore = errors;
    access(32'h8000_0200, szWord, 1'b0, 1'b1, 1'b0, privUser);
    checkFaults(1'b0, 1'b1, 1'b0);
    access(32'h8000_0200, szWord, 1'b0, 1'b1, 1'b0, privSuper);
    checkFaults(1'b0, 1'b1, 1'b0);
    access(32'h8000_0200, szWord, 1'b1, 1'b0, 1'b0, privUser);
    checkFaults(1'b1, 1'b0, 1'b0);
    access(32'h8000_0200, szWord, 1'b0, 1'b1, 1'b0, privMachine);
    checkFaults(1'b0, 1'b0, 1'b0);
    finishTest("privilege default", errBefore);
  endtask

  task automatic testNapotNa4();
    int          errBefore;
    logic [31:0] blockBase;
    logic [31:0] offset;
    logic [31:0] otherWord;
    errBefore = errors;
    blockBase = 32'h8000_1000;
    offset    = $random(seed) & 32'h0000_0FFC;
    otherWord = blockBase + ((offset + 32'd4) & 32'h0000_0FFC);
    // Entry 0 covers a 4 KiB ram block, read only
    pmpWrite(1'b0, 2'd0, napotAdr(blockBase, 32'd4096));
    pmpWrite(1'b1, 2'd0, makeCfg(1'b0, pmpNapot, 1'b0, 1'b0, 1'b1));
    access(blockBase + offset, szWord, 1'b0, 1'b1, 1'b0, privUser);
    checkFaults(1'b0, 1'b0, 1'b0);
    access(blockBase + offset, szWord, 1'b0, 1'b0, 1'b1, privUser);
    checkFaults(1'b0, 1'b0, 1'b1);
    access(blockBase + 32'h1000, szWord, 1'b0, 1'b1, 1'b0, privUser);
    checkFaults(1'b0, 1'b1, 1'b0);
    // Unlocked entry does not bind machine mode
    access(blockBase + offset, szWord, 1'b0, 1'b0, 1'b1, privMachine);
    checkFaults(1'b0, 1'b0, 1'b0);
    // Same word as NA4 with read and write
    pmpWrite(1'b0, 2'd0, (blockBase + offset) >> 2);
    pmpWrite(1'b1, 2'd0, makeCfg(1'b0, pmpNa4, 1'b0, 1'b1, 1'b1));
    access(blockBase + offset, szWord, 1'b0, 1'b0, 1'b1, privUser);
    checkFaults(1'b0, 1'b0, 1'b0);
    access(blockBase + offset, szWord, 1'b0, 1'b1, 1'b0, privUser);
    checkFaults(1'b0, 1'b0, 1'b0);
    access(otherWord, szWord, 1'b0, 1'b0, 1'b1, privUser);
    checkFaults(1'b0, 1'b0, 1'b1);
    finishTest("napot and na4", errBefore);
  endtask

  task automatic testTorPriority();
    int errBefore;
    errBefore = errors;
    pmpWrite(1'b0, 2'd0, 32'h8000_2000 >> 2);
    pmpWrite(1'b1, 2'd0, makeCfg(1'b0, pmpNa4, 1'b0, 1'b0, 1'b1));
    pmpWrite(1'b0, 2'd1, 32'h8000_3000 >> 2);
    pmpWrite(1'b1, 2'd1, makeCfg(1'b0, pmpTor, 1'b1, 1'b0, 1'b0));
    // Entry 0 wins on its own word
    access(32'h8000_2000, szWord, 1'b0, 1'b1, 1'b0, privUser);
    checkFaults(1'b0, 1'b0, 1'b0);
    access(32'h8000_2000, szWord, 1'b1, 1'b0, 1'b0, privUser);
    checkFaults(1'b1, 1'b0, 1'b0);
    // Rest of the range belongs to the execute-only TOR entry
    access(32'h8000_2800, szWord, 1'b0, 1'b1, 1'b0, privUser);
    checkFaults(1'b0, 1'b1, 1'b0);
    access(32'h8000_2800, szWord, 1'b1, 1'b0, 1'b0, privUser);
    checkFaults(1'b0, 1'b0, 1'b0);
    // Top of range is exclusive
    access(32'h8000_3000, szWord, 1'b1, 1'b0, 1'b0, privUser);
    checkFaults(1'b1, 1'b0, 1'b0);
    finishTest("tor priority", errBefore);
  endtask

  task automatic testLock();
    int errBefore;
    errBefore = errors;
    pmpWrite(1'b0, 2'd2, 32'h8000_4000 >> 2);
    pmpWrite(1'b1, 2'd2, makeCfg(1'b1, pmpNa4, 1'b0, 1'b0, 1'b1));
    // A locked entry binds machine mode too
    access(32'h8000_4000, szWord, 1'b0, 1'b0, 1'b1, privMachine);
    checkFaults(1'b0, 1'b0, 1'b1);
    access(32'h8000_4000, szWord, 1'b0, 1'b1, 1'b0, privMachine);
    checkFaults(1'b0, 1'b0, 1'b0);
    // Both registers of the entry now ignore writes
    pmpWrite(1'b1, 2'd2, makeCfg(1'b0, pmpNa4, 1'b0, 1'b1, 1'b1));
    pmpWrite(1'b0, 2'd2, 32'h8000_5000 >> 2);
    access(32'h8000_4000, szWord, 1'b0, 1'b0, 1'b1, privMachine);
    checkFaults(1'b0, 1'b0, 1'b1);
    access(32'h8000_5000, szWord, 1'b0, 1'b0, 1'b1, privMachine);
    checkFaults(1'b0, 1'b0, 1'b0);
    finishTest("lock", errBefore);
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    logic released;
    errors   = 0;
    checks   = 0;
    testsRun = 0;
    seed     = 32'hd2b3_ed9a;
    initInputs();
    waitForReset(released);
    if (!released) begin
      $display("Reset was never released");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      testAttributes();
      testRegionLegality();
      testPrivDefault();
      testNapotNa4();
      testTorPriority();
      testLock();
      $display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
      if (errors == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- memCheckTop.sv
// Memory check unit top level
// Runs the region attribute check and the PMP check side by side on
// the same access and merges their faults per access kind.

`default_nettype none

module memCheckTop import memCheckPkg::*; (
  input  logic        clk,
  input  logic        arstN,
  input  paddrT       physAdr,
  input  sizeT        size,
  input  logic        execAccess,
  input  logic        readAccess,
  input  logic        writeAccess,
  input  privT        privMode,
  input  logic        pmpWrEn,
  input  logic        pmpWrCfg,
  input  logic [1:0]  pmpWrIdx,
  input  logic [31:0] pmpWrData,
  output logic        cacheable,
  output logic        idempotent,
  output logic        atomicAllowed,
  output logic        instrAccessFault,
  output logic        loadAccessFault,
  output logic        storeAccessFault
);

  logic pmaInstrFault;
  logic pmaLoadFault;
  logic pmaStoreFault;
  logic pmpInstrFault;
  logic pmpLoadFault;
  logic pmpStoreFault;

  ////////////////////
  // Checkers
  ////////////////////

  // Region attributes and legality, purely combinational
  pmaChecker u_pmaChecker (
    .physAdr,
    .size,
    .execAccess,
    .readAccess,
    .writeAccess,
    .cacheable,
    .idempotent,
    .atomicAllowed,
    .instrFault (pmaInstrFault),
    .loadFault  (pmaLoadFault),
    .storeFault (pmaStoreFault)
  );

  // Protection entries, the only clocked part of the unit
  pmpChecker u_pmpChecker (
    .clk,
    .arstN,
    .pmpWrEn,
    .pmpWrCfg,
    .pmpWrIdx,
    .pmpWrData,
    .physAdr,
    .privMode,
    .execAccess,
    .readAccess,
    .writeAccess,
    .instrFault (pmpInstrFault),
    .loadFault  (pmpLoadFault),
    .storeFault (pmpStoreFault)
  );

  // Either checker can reject an access
  assign instrAccessFault = pmaInstrFault | pmpInstrFault;
  assign loadAccessFault  = pmaLoadFault  | pmpLoadFault;
  assign storeAccessFault = pmaStoreFault | pmpStoreFault;

endmodule

`default_nettype wire

//--- pmpChecker.sv
// Physical memory protection checker
// Holds the PMP configuration bytes and address registers written by
// machine-mode software. Matches each access against the entries in
// priority order and applies the read, write and execute permissions.

`default_nettype none

`include "memCheck_config.svh"

module pmpChecker import memCheckPkg::*; (
  input  logic        clk,
  input  logic        arstN,
  input  logic        pmpWrEn,
  input  logic        pmpWrCfg,
  input  logic [1:0]  pmpWrIdx,
  input  logic [31:0] pmpWrData,
  input  paddrT       physAdr,
  input  privT        privMode,
  input  logic        execAccess,
  input  logic        readAccess,
  input  logic        writeAccess,
  output logic        instrFault,
  output logic        loadFault,
  output logic        storeFault
);

  pmpCfgT                  pmpCfg [`PMP_ENTRIES];
  pmpAdrT                  pmpAdr [`PMP_ENTRIES];
  pmpAdrT                  adrWord;
  logic [`PMP_ENTRIES-1:0] entryMatch;
  logic                    anyMatch;
  pmpCfgT                  selCfg;
  logic                    notMachine;
  logic                    enforce;

  ////////////////////
  // Register file
  ////////////////////

  // The lock bit of the addressed entry blocks both its configuration
  // byte and its address register until the next reset
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `PMP_ENTRIES; i++) begin
        pmpCfg[i] <= '0;
        pmpAdr[i] <= '0;
      end
    end else if (pmpWrEn && !pmpCfg[pmpWrIdx][cfgLock]) begin
      if (pmpWrCfg) begin
        pmpCfg[pmpWrIdx] <= pmpWrData[7:0];
      end else begin
        pmpAdr[pmpWrIdx] <= pmpWrData[$bits(pmpAdrT)-1:0];
      end
    end
  end

  ////////////////////
  // Entry matching
  ////////////////////

  // Address registers hold the address divided by four, so compare
  // at word granularity
  assign adrWord = physAdr[`PA_BITS-1:2];

  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : gEntry
    pmpAdrT     torBase;
    pmpAdrT     napotCare;
    logic [1:0] mode;
    logic       torHit;
    logic       na4Hit;
    logic       napotHit;

    // Matching mode sits in bits 4:3 of the configuration byte
    assign mode = pmpCfg[i][4:3];

    // Entry 0 has its range starting at address zero
    if (i == 0) begin : gFirst
      assign torBase = '0;
    end else begin : gNext
      assign torBase = pmpAdr[i-1];
    end

    // Top of range, lower bound inclusive and upper bound exclusive
    assign torHit = (adrWord >= torBase) && (adrWord < pmpAdr[i]);

    assign na4Hit = (adrWord == pmpAdr[i]);

    // Adding one turns the trailing ones into zeros and carries into the
    // next zero, so the XOR marks exactly the bits inside the block
    assign napotCare = ~(pmpAdr[i] ^ (pmpAdr[i] + 1'b1));
    assign napotHit  = ((adrWord ^ pmpAdr[i]) & napotCare) == '0;

    assign entryMatch[i] = (mode == pmpOff)   ? 1'b0 :
                           (mode == pmpTor)   ? torHit :
                           (mode == pmpNa4)   ? na4Hit :
                                                napotHit;
  end

  // Walk from the highest entry down so the lowest matching one is kept
  always_comb begin
    anyMatch = 1'b0;
    selCfg   = '0;
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--) begin
      if (entryMatch[i]) begin
        anyMatch = 1'b1;
        selCfg   = pmpCfg[i];
      end
    end
  end

  ////////////////////
  // Permission check
  ////////////////////

  assign notMachine = (privMode != privMachine);

  // Machine mode is only held to the permissions of a locked entry
  assign enforce = notMachine | selCfg[cfgLock];

  // Without a matching entry only machine mode gets through
  assign instrFault = execAccess &
                      (anyMatch ? (enforce & ~selCfg[cfgExec]) : notMachine);
  assign loadFault  = readAccess &
                      (anyMatch ? (enforce & ~selCfg[cfgRead]) : notMachine);
  assign storeFault = writeAccess &
                      (anyMatch ? (enforce & ~selCfg[cfgWrite]) : notMachine);

endmodule

`default_nettype wire

//--- pmaChecker.sv
// Physical memory attribute checker
// Finds the region an access targets and reports its attributes.
// Raises a fault per access kind when no region accepts the access.

`default_nettype none

module pmaChecker import memCheckPkg::*; (
  input  paddrT physAdr,
  input  sizeT  size,
  input  logic  execAccess,
  input  logic  readAccess,
  input  logic  writeAccess,
  output logic  cacheable,
  output logic  idempotent,
  output logic  atomicAllowed,
  output logic  instrFault,
  output logic  loadFault,
  output logic  storeFault
);

  logic      accessRW;
  logic      accessRX;
  logic      accessRWX;
  regionSelT regionSel;

  ////////////////////
  // Access groups
  ////////////////////
  // Each region accepts one of these groups
  assign accessRW  = readAccess | writeAccess;
  assign accessRX  = readAccess | execAccess;
  assign accessRWX = readAccess | writeAccess | execAccess;

  // Region decode
  adrDecs u_adrDecs (
    .physAdr,
    .size,
    .accessRW,
    .accessRX,
    .accessRWX,
    .regionSel
  );

  ////////////////////
  // Attributes
  ////////////////////
  // Ram, dtim and flash are all cacheable
  assign cacheable = regionSel[regionRam] | regionSel[regionDtim] | regionSel[regionFlash];

  // Flash is left out here since reads may have side effects during programming
  assign idempotent    = regionSel[regionRam] | regionSel[regionDtim];
  assign atomicAllowed = regionSel[regionRam] | regionSel[regionDtim];

  // Each fault is qualified by its own access kind since the no-hit bit
  // is also high when no access is made
  assign instrFault = execAccess  & regionSel[regionNone];
  assign loadFault  = readAccess  & regionSel[regionNone];
  assign storeFault = writeAccess & regionSel[regionNone];

endmodule

`default_nettype wire

//--- adrDecs.sv
// Physical memory map decoder
// One decoder per region, each with its own access group and allowed
// sizes. The top bit of the result flags an address that no region takes.

`default_nettype none

`include "memCheck_config.svh"

module adrDecs import memCheckPkg::*; (
  input  paddrT     physAdr,
  input  sizeT      size,
  input  logic      accessRW,
  input  logic      accessRX,
  input  logic      accessRWX,
  output regionSelT regionSel
);

  // Size enables, one bit per size code
  localparam logic [3:0] sizeAny  = 4'b1111;
  localparam logic [3:0] sizeWord = 4'b0100;
  localparam logic [3:0] sizeByte = 4'b0001;

  ////////////////////
  // Region map
  ////////////////////

  // Boot code is fetched and read but never written
  adrDec u_bootRomDec (
    .physAdr, .accessAllowed(accessRX), .size, .sizeMask(sizeAny),
    .base(`BOOTROM_BASE), .mask(`BOOTROM_MASK), .hit(regionSel[regionBootRom])
  );

  // Peripheral register blocks take full word reads and writes only
  adrDec u_clintDec (
    .physAdr, .accessAllowed(accessRW), .size, .sizeMask(sizeWord),
    .base(`CLINT_BASE), .mask(`CLINT_MASK), .hit(regionSel[regionClint])
  );
  adrDec u_gpioDec (
    .physAdr, .accessAllowed(accessRW), .size, .sizeMask(sizeWord),
    .base(`GPIO_BASE), .mask(`GPIO_MASK), .hit(regionSel[regionGpio])
  );

  // The UART has byte-wide registers
  adrDec u_uartDec (
    .physAdr, .accessAllowed(accessRW), .size, .sizeMask(sizeByte),
    .base(`UART_BASE), .mask(`UART_MASK), .hit(regionSel[regionUart])
  );
  adrDec u_plicDec (
    .physAdr, .accessAllowed(accessRW), .size, .sizeMask(sizeWord),
    .base(`PLIC_BASE), .mask(`PLIC_MASK), .hit(regionSel[regionPlic])
  );

  // Memories allow any size, flash is read-only
  adrDec u_dtimDec (
    .physAdr, .accessAllowed(accessRWX), .size, .sizeMask(sizeAny),
    .base(`DTIM_BASE), .mask(`DTIM_MASK), .hit(regionSel[regionDtim])
  );
  adrDec u_flashDec (
    .physAdr, .accessAllowed(accessRX), .size, .sizeMask(sizeAny),
    .base(`FLASH_BASE), .mask(`FLASH_MASK), .hit(regionSel[regionFlash])
  );
  adrDec u_ramDec (
    .physAdr, .accessAllowed(accessRWX), .size, .sizeMask(sizeAny),
    .base(`RAM_BASE), .mask(`RAM_MASK), .hit(regionSel[regionRam])
  );

  // Nothing claimed the address, or the access was illegal everywhere
  assign regionSel[regionNone] = ~|regionSel[regionRam:regionBootRom];

endmodule

`default_nettype wire

//--- adrDec.sv
// Single region address decoder
// Flags a hit when the address falls in the region, the kind of
// access is allowed there and the access size is one the region takes.

`default_nettype none

module adrDec import memCheckPkg::*; (
  input  paddrT      physAdr,
  input  logic       accessAllowed,
  input  sizeT       size,
  input  logic [3:0] sizeMask,
  input  paddrT      base,
  input  paddrT      mask,
  output logic       hit
);

  logic adrMatch;
  logic sizeOk;

  // Only the bits selected by the mask take part in the compare
  // so the low bits inside the region are free
  assign adrMatch = ((physAdr & mask) == base);

  // Each bit of sizeMask enables one size code, bit 0 for byte up to
  // bit 3 for double
  assign sizeOk = sizeMask[size];

  // A wrong kind or size of access makes the region look absent, which
  // later turns into an access fault through the no-hit bit
  assign hit = adrMatch & accessAllowed & sizeOk;

endmodule

`default_nettype wire

//--- memCheckPkg.sv
// Memory check package
// Shared vector types, region bit indices and PMP encodings
// used by the PMA and PMP checkers.

`default_nettype none

`include "memCheck_config.svh"

package memCheckPkg;

  // Physical address and access size (0 byte, 1 half, 2 word, 3 double)
  typedef logic [`PA_BITS-1:0] paddrT;
  typedef logic [1:0]          sizeT;

  // One bit per region plus the no-hit bit at the top
  typedef logic [8:0]          regionSelT;

  // Privilege mode, 0 user, 1 supervisor, 3 machine
  typedef logic [1:0]          privT;

  // PMP configuration byte and address register (address divided by four)
  typedef logic [7:0]          pmpCfgT;
  typedef logic [`PA_BITS-3:0] pmpAdrT;

  ////////////////////
  // Region indices
  ////////////////////
  parameter int unsigned regionBootRom = 0;
  parameter int unsigned regionClint   = 1;
  parameter int unsigned regionGpio    = 2;
  parameter int unsigned regionUart    = 3;
  parameter int unsigned regionPlic    = 4;
  parameter int unsigned regionDtim    = 5;
  parameter int unsigned regionFlash   = 6;
  parameter int unsigned regionRam     = 7;
  parameter int unsigned regionNone    = 8;

  ////////////////////
  // PMP encodings
  ////////////////////
  // Matching modes held in bits 4:3 of a configuration byte
  parameter logic [1:0] pmpOff   = 2'd0;
  parameter logic [1:0] pmpTor   = 2'd1;
  parameter logic [1:0] pmpNa4   = 2'd2;
  parameter logic [1:0] pmpNapot = 2'd3;

  // Bit positions inside a configuration byte
  parameter int unsigned cfgRead  = 0;
  parameter int unsigned cfgWrite = 1;
  parameter int unsigned cfgExec  = 2;
  parameter int unsigned cfgLock  = 7;

  parameter privT privMachine = 2'd3;

endpackage

`default_nettype wire

//--- memCheck_config.svh
// Memory check unit configuration
// Address width, PMP entry count and the physical memory map.
// A region is hit when (address & mask) == base.

`ifndef MEMCHECK_CONFIG_SVH
`define MEMCHECK_CONFIG_SVH

// Physical address width in bits
`define PA_BITS 32

// Number of PMP entries held by the PMP checker
`define PMP_ENTRIES 4

////////////////////
// Region map
////////////////////

// Boot ROM, 4 KiB
`define BOOTROM_BASE 32'h0000_1000
`define BOOTROM_MASK 32'hFFFF_F000
// Core-local interruptor, 64 KiB
`define CLINT_BASE   32'h0200_0000
`define CLINT_MASK   32'hFFFF_0000
// GPIO block, 4 KiB
`define GPIO_BASE    32'h1006_0000
`define GPIO_MASK    32'hFFFF_F000
// UART registers, 256 bytes
`define UART_BASE    32'h1000_0000
`define UART_MASK    32'hFFFF_FF00
// Platform interrupt controller, 64 MiB window
`define PLIC_BASE    32'h0C00_0000
`define PLIC_MASK    32'hFC00_0000
// Tightly coupled data memory, 64 KiB
`define DTIM_BASE    32'h7000_0000
`define DTIM_MASK    32'hFFFF_0000
// Execute-in-place flash, 256 MiB
`define FLASH_BASE   32'h2000_0000
`define FLASH_MASK   32'hF000_0000
// Main memory, 256 MiB
`define RAM_BASE     32'h8000_0000
`define RAM_MASK     32'hF000_0000

`endif
